// File: flist.f
+incdir+.
rv_pkg.sv
rv_ctrl_if.sv
rv_ctrl_decoder.sv
rv_imm_gen.sv
rv_decode_issue.sv
rv_decode_top.sv
tb_rv_decode.sv

// File: tb_rv_decode.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_decode import rv_pkg::*; ();

  localparam int n_directed  = 42;
  localparam int n_random    = 200;
  localparam int cycle_limit = (n_directed + n_random) * 16;

  logic      clk;
  logic      arst_n;
  logic      in_req;
  logic      in_ack;
  word_t     instr;
  word_t     pc;
  logic      out_req;
  logic      out_ack;
  reg_idx_t  rs1, rs2, rd;
  logic      reg_write, mem_write, mem_read, mem_unsigned, alu_b_imm;
  mem_size_t mem_size;
  alu_op_t   alu_op;
  logic      branch_op, jump_op, syscall_op, break_op, mret_op, illegal;
  word_t     imm_out;
  word_t     target;

  // Reference model results for the transaction in flight
  reg_idx_t  exp_rs1, exp_rs2, exp_rd;
  logic      exp_reg_write, exp_mem_write, exp_mem_read, exp_mem_unsigned, exp_alu_b_imm;
  mem_size_t exp_mem_size;
  alu_op_t   exp_alu_op;
  logic      exp_branch_op, exp_jump_op, exp_syscall_op, exp_break_op, exp_mret_op;
  logic      exp_illegal;
  word_t     exp_imm;
  word_t     exp_target;

  logic [31:0] exp_ctrl;
  logic [31:0] act_ctrl;
  logic [31:0] lfsr_state = 32'he3c2ae23;
  word_t       directed [n_directed];
  logic [6:0]  opcodes [10];
  int          errors = 0;
  int          n_txn = 0;
  int          cycles = 0;

  assign exp_ctrl = {exp_rs1, exp_rs2, exp_rd, exp_reg_write, exp_mem_write, exp_mem_read,
                     exp_mem_size, exp_mem_unsigned, exp_alu_op, exp_alu_b_imm, exp_branch_op,
                     exp_jump_op, exp_syscall_op, exp_break_op, exp_mret_op, exp_illegal};
  assign act_ctrl = {rs1, rs2, rd, reg_write, mem_write, mem_read, mem_size, mem_unsigned,
                     alu_op, alu_b_imm, branch_op, jump_op, syscall_op, break_op, mret_op,
                     illegal};

  rv_decode_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: handshake did not complete within %0d cycles", cycle_limit);
      $display("Transactions: %0d, errors: %0d", n_txn, errors);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic report_field(input string name, input logic [31:0] e, input logic [31:0] a);
    if (e !== a) begin
      errors++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, e, a);
    end
  endtask

  task automatic count_failure(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic report_ctrl();
    report_field("rs1", exp_rs1, rs1);
    report_field("rs2", exp_rs2, rs2);
    report_field("rd", exp_rd, rd);
    report_field("reg_write", exp_reg_write, reg_write);
    report_field("mem_write", exp_mem_write, mem_write);
    report_field("mem_read", exp_mem_read, mem_read);
    report_field("mem_size", exp_mem_size, mem_size);
    report_field("mem_unsigned", exp_mem_unsigned, mem_unsigned);
    report_field("alu_op", exp_alu_op, alu_op);
    report_field("alu_b_imm", exp_alu_b_imm, alu_b_imm);
    report_field("branch_op", exp_branch_op, branch_op);
    report_field("jump_op", exp_jump_op, jump_op);
    report_field("syscall_op", exp_syscall_op, syscall_op);
    report_field("break_op", exp_break_op, break_op);
    report_field("mret_op", exp_mret_op, mret_op);
    report_field("illegal", exp_illegal, illegal);
  endtask

  // Register-register and register-immediate ALU selection
  function automatic alu_op_t expected_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? `alu_sub : `alu_add;
      3'd1:    return `alu_sll;
      3'd2:    return `alu_slt;
      3'd3:    return `alu_sltu;
      3'd4:    return `alu_xor;
      3'd5:    return alt ? `alu_sra : `alu_srl;
      3'd6:    return `alu_or;
      default: return `alu_and;
    endcase
  endfunction

  task automatic predict(input word_t w, input word_t p);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    logic       pc_rel;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    ok = 1'b1;
    pc_rel = 1'b0;
    exp_rs1 = w[19:15];
    exp_rs2 = w[24:20];
    exp_rd = w[11:7];
    {exp_reg_write, exp_mem_write, exp_mem_read, exp_mem_unsigned, exp_alu_b_imm} = '0;
    {exp_branch_op, exp_jump_op, exp_syscall_op, exp_break_op, exp_mret_op} = '0;
    exp_mem_size = '0;
    exp_alu_op = `alu_add;
    exp_imm = '0;
    case (op)
      `op_lui, `op_auipc: begin
        exp_reg_write = 1'b1;
        exp_imm = {w[31:12], 12'h000};
        pc_rel = (op == `op_auipc);
      end
      `op_jal: begin
        exp_reg_write = 1'b1;
        exp_jump_op = 1'b1;
        pc_rel = 1'b1;
        exp_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      `op_jalr: begin
        ok = (f3 == 3'd0);
        exp_reg_write = 1'b1;
        exp_jump_op = 1'b1;
        exp_alu_b_imm = 1'b1;
        exp_imm = {{20{w[31]}}, w[31:20]};
      end
      `op_branch: begin
        ok = (f3 != 3'd2) && (f3 != 3'd3);
        exp_branch_op = 1'b1;
        exp_alu_op = `alu_sub;
        pc_rel = 1'b1;
        exp_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      `op_load: begin
        ok = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        exp_reg_write = 1'b1;
        exp_mem_read = 1'b1;
        exp_alu_b_imm = 1'b1;
        exp_mem_size = f3[1:0];
        exp_mem_unsigned = f3[2];
        exp_imm = {{20{w[31]}}, w[31:20]};
      end
      `op_store: begin
        ok = (f3 < 3'd3);
        exp_mem_write = 1'b1;
        exp_alu_b_imm = 1'b1;
        exp_mem_size = f3[1:0];
        exp_imm = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      `op_imm: begin
        ok = (f3 == 3'd1) ? (f7 == 7'h00) : (f3 == 3'd5) ? (f7 inside {7'h00, 7'h20}) : 1'b1;
        exp_reg_write = 1'b1;
        exp_alu_b_imm = 1'b1;
        exp_alu_op = expected_alu(f3, (f3 == 3'd5) && f7[5]);
        exp_imm = {{20{w[31]}}, w[31:20]};
      end
      `op_reg: begin
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        exp_reg_write = 1'b1;
        exp_alu_op = expected_alu(f3, f7[5]);
      end
      `op_system: begin
        exp_syscall_op = (w[31:7] == 25'd0);
        exp_break_op = (w[31:7] == {12'h001, 13'd0});
        exp_mret_op = (w[31:7] == {12'h302, 13'd0});
        ok = exp_syscall_op || exp_break_op || exp_mret_op;
      end
      default: ok = 1'b0;
    endcase
    // Illegal encodings keep the immediate but drop every side effect
    if (!ok) begin
      {exp_reg_write, exp_mem_write, exp_mem_read, exp_mem_unsigned, exp_alu_b_imm} = '0;
      {exp_branch_op, exp_jump_op} = '0;
      exp_mem_size = '0;
      exp_alu_op = `alu_add;
      pc_rel = 1'b0;
    end
    exp_illegal = !ok;
    exp_target = pc_rel ? p + exp_imm : '0;
  endtask

  // Execute side of the result on offer, if any
  task automatic drain_output(input logic [31:0] d_ack);
    if (out_req) begin
      repeat (d_ack) @(negedge clk);
      out_ack = 1'b1;
      while (out_req) @(negedge clk);
      out_ack = 1'b0;
    end
  endtask

  // Returns once out_req for this instruction is up and has been checked
  task automatic feed_input(input word_t w, input word_t p, input logic [31:0] d_req);
    predict(w, p);
    instr = w;
    pc = p;
    in_req = 1'b1;
    while (!in_ack) @(negedge clk);
    repeat (d_req) @(negedge clk);
    in_req = 1'b0;
    while (!out_req) @(negedge clk);
    @(negedge clk);
    n_txn++;
  endtask

  // Next instruction waits on in_req while the previous result is still offered
  task automatic run_txn(input word_t w, input word_t p, input logic [31:0] d_req,
                         input logic [31:0] d_ack, input logic overlap);
    if (overlap) begin
      fork
        drain_output(d_ack);
        feed_input(w, p, d_req);
      join
    end else begin
      drain_output(d_ack);
      @(negedge clk);
      feed_input(w, p, d_req);
    end
  endtask

  reset_idle_a: assert property (@(posedge clk) $rose(arst_n) |-> !in_ack && !out_req)
    else count_failure("in_ack or out_req high after reset");

  ack_timing_a: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(in_req) && !out_req && !out_ack |=> $rose(in_ack))
    else count_failure("in_ack did not rise one cycle after in_req");

  ack_after_release_a: assert property (@(posedge clk) disable iff (!arst_n)
    in_req && $fell(out_req) |=> ##1 $rose(in_ack))
    else count_failure("in_ack late after the output handshake ended");

  launch_timing_a: assert property (@(posedge clk) disable iff (!arst_n)
    in_ack && $fell(in_req) |=> $rose(out_req))
    else count_failure("out_req did not rise when in_req was seen low");

  in_release_a: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(in_ack) |-> !$past(in_req))
    else count_failure("in_ack dropped while in_req was still high");

  out_release_a: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(out_req) |-> $past(out_ack))
    else count_failure("out_req dropped before out_ack rose");

  no_early_ack_a: assert property (@(posedge clk) disable iff (!arst_n)
    (out_req || out_ack) |-> !in_ack)
    else count_failure("new in_ack before the output handshake completed");

  hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_req && !out_ack |=> $stable(act_ctrl) && $stable(imm_out) && $stable(target))
    else count_failure("outputs changed while offered to execute");

  ctrl_match_a: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(out_req) |-> act_ctrl == exp_ctrl)
    else report_ctrl();

  imm_match_a: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(out_req) |-> imm_out == exp_imm)
    else report_field("imm_out", exp_imm, imm_out);

  target_match_a: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(out_req) |-> target == exp_target)
    else report_field("target", exp_target, target);

  illegal_quiet_a: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(out_req) && illegal |-> !(reg_write || mem_write || mem_read || branch_op || jump_op))
    else count_failure("illegal instruction left a write, memory or control flag high");

  initial begin
    word_t       w;
    logic [31:0] p;
    logic [31:0] r;
    logic [31:0] d_req;
    logic [31:0] d_ack;
    arst_n = 1'b0;
    in_req = 1'b0;
    out_ack = 1'b0;
    instr = '0;
    pc = '0;
    opcodes = '{`op_lui, `op_auipc, `op_jal, `op_jalr, `op_branch,
                `op_load, `op_store, `op_imm, `op_reg, `op_system};
    // Every RV32I instruction, then mret, fence and csrrw
    directed = '{
      {20'hfffff, 5'd1, `op_lui}, {20'h80000, 5'd2, `op_auipc},
      {1'b1, 10'h3fe, 1'b1, 8'hff, 5'd1, `op_jal}, {12'hffc, 5'd5, 3'd0, 5'd1, `op_jalr},
      {7'h7f, 5'd2, 5'd1, 3'd0, 5'h1d, `op_branch}, {7'h00, 5'd3, 5'd4, 3'd1, 5'h08, `op_branch},
      {7'h01, 5'd5, 5'd6, 3'd4, 5'h10, `op_branch}, {7'h7e, 5'd7, 5'd8, 3'd5, 5'h01, `op_branch},
      {7'h00, 5'd9, 5'd10, 3'd6, 5'h04, `op_branch}, {7'h40, 5'd11, 5'd12, 3'd7, 5'h02, `op_branch},
      {12'h800, 5'd1, 3'd0, 5'd2, `op_load}, {12'h002, 5'd3, 3'd1, 5'd4, `op_load},
      {12'hffc, 5'd5, 3'd2, 5'd6, `op_load}, {12'h7ff, 5'd7, 3'd4, 5'd8, `op_load},
      {12'hfff, 5'd9, 3'd5, 5'd10, `op_load}, {7'h7f, 5'd1, 5'd2, 3'd0, 5'h1f, `op_store},
      {7'h00, 5'd3, 5'd4, 3'd1, 5'h04, `op_store}, {7'h40, 5'd5, 5'd6, 3'd2, 5'h00, `op_store},
      {12'hfff, 5'd1, 3'd0, 5'd1, `op_imm}, {12'h800, 5'd2, 3'd2, 5'd3, `op_imm},
      {12'h001, 5'd4, 3'd3, 5'd5, `op_imm}, {12'hf0f, 5'd6, 3'd4, 5'd7, `op_imm},
      {12'h0ff, 5'd8, 3'd6, 5'd9, `op_imm}, {12'h80f, 5'd10, 3'd7, 5'd11, `op_imm},
      {7'h00, 5'd31, 5'd2, 3'd1, 5'd3, `op_imm}, {7'h00, 5'd4, 5'd5, 3'd5, 5'd6, `op_imm},
      {7'h20, 5'd7, 5'd8, 3'd5, 5'd9, `op_imm}, {7'h00, 5'd1, 5'd2, 3'd0, 5'd3, `op_reg},
      {7'h20, 5'd4, 5'd5, 3'd0, 5'd6, `op_reg}, {7'h00, 5'd7, 5'd8, 3'd1, 5'd9, `op_reg},
      {7'h00, 5'd10, 5'd11, 3'd2, 5'd12, `op_reg}, {7'h00, 5'd13, 5'd14, 3'd3, 5'd15, `op_reg},
      {7'h00, 5'd16, 5'd17, 3'd4, 5'd18, `op_reg}, {7'h00, 5'd19, 5'd20, 3'd5, 5'd21, `op_reg},
      {7'h20, 5'd22, 5'd23, 3'd5, 5'd24, `op_reg}, {7'h00, 5'd25, 5'd26, 3'd6, 5'd27, `op_reg},
      {7'h00, 5'd28, 5'd29, 3'd7, 5'd30, `op_reg}, 32'h0000_0073, 32'h0010_0073,
      32'h3020_0073, 32'h0ff0_000f, 32'h3002_9073
    };
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    foreach (directed[i]) begin
      take_bits(32, p);
      take_bits(2, d_req);
      take_bits(2, d_ack);
      take_bits(1, r);
      run_txn(directed[i], p, d_req, d_ack, r[0]);
    end
    repeat (n_random) begin
      take_bits(1, r);
      if (r[0]) begin
        take_bits(32, w);
      end else begin
        take_bits(4, r);
        take_bits(25, p);
        w = {p[24:0], opcodes[r % 10]};
      end
      take_bits(32, p);
      take_bits(2, d_req);
      take_bits(2, d_ack);
      take_bits(1, r);
      run_txn(w, p, d_req, d_ack, r[0]);
    end
    take_bits(2, d_ack);
    drain_output(d_ack);
    repeat (2) @(negedge clk);
    $display("Transactions: %0d, errors: %0d", n_txn, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: rv_decode_top.sv
`timescale 1ns/1ps

module rv_decode_top import rv_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_req,
  output logic      in_ack,
  input  word_t     instr,
  input  word_t     pc,
  output logic      out_req,
  input  logic      out_ack,
  output reg_idx_t  rs1,
  output reg_idx_t  rs2,
  output reg_idx_t  rd,
  output logic      reg_write,
  output logic      mem_write,
  output logic      mem_read,
  output mem_size_t mem_size,
  output logic      mem_unsigned,
  output alu_op_t   alu_op,
  output logic      alu_b_imm,
  output logic      branch_op,
  output logic      jump_op,
  output logic      syscall_op,
  output logic      break_op,
  output logic      mret_op,
  output logic      illegal,
  output word_t     imm_out,
  output word_t     target
);

  word_t inst_q;
  word_t imm;

  rv_ctrl_if i_ctrl_if ();

  // Both side blocks work on the captured instruction
  rv_ctrl_decoder i_ctrl_decoder (
    .inst (inst_q),
    .ctrl (i_ctrl_if)
  );

  rv_imm_gen i_imm_gen (
    .inst (inst_q),
    .imm  (imm)
  );

  rv_decode_issue i_decode_issue (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_req       (in_req),
    .in_ack       (in_ack),
    .instr        (instr),
    .pc           (pc),
    .inst_q       (inst_q),
    .ctrl         (i_ctrl_if),
    .imm          (imm),
    .out_req      (out_req),
    .out_ack      (out_ack),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .reg_write    (reg_write),
    .mem_write    (mem_write),
    .mem_read     (mem_read),
    .mem_size     (mem_size),
    .mem_unsigned (mem_unsigned),
    .alu_op       (alu_op),
    .alu_b_imm    (alu_b_imm),
    .branch_op    (branch_op),
    .jump_op      (jump_op),
    .syscall_op   (syscall_op),
    .break_op     (break_op),
    .mret_op      (mret_op),
    .illegal      (illegal),
    .imm_out      (imm_out),
    .target       (target)
  );

endmodule

// File: rv_decode_issue.sv
`timescale 1ns/1ps

module rv_decode_issue import rv_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            in_req,
  output logic            in_ack,
  input  word_t           instr,
  input  word_t           pc,
  output word_t           inst_q,
  rv_ctrl_if.issue        ctrl,
  input  word_t           imm,
  output logic            out_req,
  input  logic            out_ack,
  output reg_idx_t        rs1,
  output reg_idx_t        rs2,
  output reg_idx_t        rd,
  output logic            reg_write,
  output logic            mem_write,
  output logic            mem_read,
  output mem_size_t       mem_size,
  output logic            mem_unsigned,
  output alu_op_t         alu_op,
  output logic            alu_b_imm,
  output logic            branch_op,
  output logic            jump_op,
  output logic            syscall_op,
  output logic            break_op,
  output logic            mret_op,
  output logic            illegal,
  output word_t           imm_out,
  output word_t           target
);

  issue_state_t state;
  word_t        pc_q;
  logic         capture;
  logic         launch;

  assign capture = (state == IDLE) && in_req;
  assign launch  = (state == ACK) && !in_req;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      in_ack  <= 1'b0;
      out_req <= 1'b0;
    end else begin
      case (state)
        IDLE: if (in_req) begin
          in_ack <= 1'b1;
          state  <= ACK;
        end
        ACK: if (!in_req) begin
          in_ack  <= 1'b0;
          out_req <= 1'b1;
          state   <= OFFER;
        end
        OFFER: if (out_ack) begin
          out_req <= 1'b0;
          state   <= RELEASE;
        end
        // Wait for execute to drop ack before taking new work
        RELEASE: if (!out_ack) begin
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_write    <= 1'b0;
      mem_write    <= 1'b0;
      mem_read     <= 1'b0;
      mem_unsigned <= 1'b0;
      alu_b_imm    <= 1'b0;
      branch_op    <= 1'b0;
      jump_op      <= 1'b0;
      syscall_op   <= 1'b0;
      break_op     <= 1'b0;
      mret_op      <= 1'b0;
      illegal      <= 1'b0;
    end else if (launch) begin
      reg_write    <= ctrl.reg_write;
      mem_write    <= ctrl.mem_write;
      mem_read     <= ctrl.mem_read;
      mem_unsigned <= ctrl.mem_unsigned;
      alu_b_imm    <= ctrl.alu_b_imm;
      branch_op    <= ctrl.branch_op;
      jump_op      <= ctrl.jump_op;
      syscall_op   <= ctrl.syscall_op;
      break_op     <= ctrl.break_op;
      mret_op      <= ctrl.mret_op;
      illegal      <= ctrl.illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      inst_q <= instr;
      pc_q   <= pc;
    end
    if (launch) begin
      rs1      <= inst_q[19:15];
      rs2      <= inst_q[24:20];
      rd       <= inst_q[11:7];
      mem_size <= ctrl.mem_size;
      alu_op   <= ctrl.alu_op;
      imm_out  <= imm;
      // jal, branches and auipc only
      target   <= ctrl.pc_rel ? pc_q + imm : '0;
    end
  end

  ack_after_req_a: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(in_ack) |-> $past(in_req))
    else $error("in_ack rose without in_req");

  hold_while_offered_a: assert property (@(posedge clk) disable iff (!arst_n)
    (out_req && !out_ack) |=> $stable({rs1, rs2, rd, reg_write, mem_write, mem_read,
                                       mem_size, mem_unsigned, alu_op, alu_b_imm,
                                       branch_op, jump_op, syscall_op, break_op,
                                       mret_op, illegal, imm_out, target}))
    else $error("decode outputs changed while offered");

endmodule

// File: rv_imm_gen.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_imm_gen import rv_pkg::*; (
  input  word_t inst,
  output word_t imm
);

  logic [6:0] opcode;
  logic       sign;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign opcode = inst[6:0];
  assign sign   = inst[31];

  // jalr, loads, op_imm
  assign imm_i = {{20{sign}}, inst[31:20]};

  assign imm_s = {{20{sign}}, inst[31:25], inst[11:7]};

  // Branch offsets are in halfwords
  assign imm_b = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  assign imm_u = {inst[31:12], 12'b0};

  assign imm_j = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // Format depends on the opcode alone
  always_comb begin
    case (opcode)
      `op_jalr,
      `op_load,
      `op_imm:    imm = imm_i;
      `op_store:  imm = imm_s;
      `op_branch: imm = imm_b;
      `op_lui,
      `op_auipc:  imm = imm_u;
      `op_jal:    imm = imm_j;
      default:    imm = '0;
    endcase
  end

endmodule

// File: rv_ctrl_decoder.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_ctrl_decoder import rv_pkg::*; (
  input word_t       inst,
  rv_ctrl_if.decoder ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  logic is_lui;
  logic is_auipc;
  logic is_upper;
  logic is_jal;
  logic is_jalr;
  logic is_branch;
  logic is_load;
  logic is_store;
  logic is_imm_alu;
  logic is_reg_alu;
  logic is_alu;
  logic is_sub;
  logic is_srai;
  logic is_sra;
  logic is_ecall;
  logic is_ebreak;
  logic is_mret;
  logic valid;
  logic imm_funct7_ok;
  logic reg_funct7_ok;

  alu_op_t alu_sel;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Shift immediates carry funct7 in the upper bits
  assign imm_funct7_ok = (funct3 == `f3_sll) ? (funct7 == `f7_base) :
                         (funct3 == `f3_sr)  ? (funct7 inside {`f7_base, `f7_alt}) :
                                               1'b1;

  // Only add/sub and srl/sra have an alternate funct7
  assign reg_funct7_ok = (funct7 == `f7_base) ||
                         (funct7 == `f7_alt && funct3 inside {`f3_add_sub, `f3_sr});

  assign is_lui     = (opcode == `op_lui);
  assign is_auipc   = (opcode == `op_auipc);
  assign is_jal     = (opcode == `op_jal);
  assign is_jalr    = (opcode == `op_jalr) && (funct3 == `f3_jalr);
  assign is_branch  = (opcode == `op_branch) &&
                      (funct3 inside {`f3_beq, `f3_bne, `f3_blt, `f3_bge, `f3_bltu, `f3_bgeu});
  assign is_load    = (opcode == `op_load) &&
                      (funct3 inside {`f3_lb, `f3_lh, `f3_lw, `f3_lbu, `f3_lhu});
  assign is_store   = (opcode == `op_store) && (funct3 inside {`f3_sb, `f3_sh, `f3_sw});
  assign is_imm_alu = (opcode == `op_imm) && imm_funct7_ok;
  assign is_reg_alu = (opcode == `op_reg) && reg_funct7_ok;

  assign is_ecall  = (opcode == `op_system) && (inst[31:7] == `sys_ecall);
  assign is_ebreak = (opcode == `op_system) && (inst[31:7] == `sys_ebreak);
  assign is_mret   = (opcode == `op_system) && (inst[31:7] == `sys_mret);

  assign is_upper = is_lui | is_auipc;
  assign is_alu   = is_imm_alu | is_reg_alu;
  assign is_sub   = is_reg_alu && (funct3 == `f3_add_sub) && (funct7 == `f7_alt);
  assign is_srai  = is_imm_alu && (funct3 == `f3_sr) && (funct7 == `f7_alt);
  assign is_sra   = is_reg_alu && (funct3 == `f3_sr) && (funct7 == `f7_alt);

  // CSR ops and fence fall through as illegal
  assign valid = |{is_upper, is_jal, is_jalr, is_branch, is_load, is_store,
                   is_alu, is_ecall, is_ebreak, is_mret};

  always_comb begin
    alu_sel = `alu_add;
    if (is_branch || is_sub) begin
      alu_sel = `alu_sub;
    end else if (is_alu) begin
      case (funct3)
        `f3_sll:  alu_sel = `alu_sll;
        `f3_slt:  alu_sel = `alu_slt;
        `f3_sltu: alu_sel = `alu_sltu;
        `f3_xor:  alu_sel = `alu_xor;
        `f3_sr:   alu_sel = (is_sra | is_srai) ? `alu_sra : `alu_srl;
        `f3_or:   alu_sel = `alu_or;
        `f3_and:  alu_sel = `alu_and;
        default:  alu_sel = `alu_add;
      endcase
    end
  end

  // Every flag below is qualified by a legal encoding
  assign ctrl.reg_write    = is_alu | is_load | is_upper | is_jal | is_jalr;
  assign ctrl.mem_write    = is_store;
  assign ctrl.mem_read     = is_load;
  assign ctrl.mem_size     = (is_load | is_store) ? mem_size_t'(funct3[1:0]) : '0;
  assign ctrl.mem_unsigned = is_load & funct3[2];
  assign ctrl.alu_op       = alu_sel;
  assign ctrl.alu_b_imm    = is_imm_alu | is_load | is_store | is_jalr;
  assign ctrl.branch_op    = is_branch;
  assign ctrl.jump_op      = is_jal | is_jalr;
  assign ctrl.pc_rel       = is_jal | is_branch | is_auipc;
  assign ctrl.syscall_op   = is_ecall;
  assign ctrl.break_op     = is_ebreak;
  assign ctrl.mret_op      = is_mret;
  assign ctrl.illegal      = ~valid;

  mem_excl_a: assert final (!(ctrl.mem_write && ctrl.mem_read))
    else $error("mem_write and mem_read both high for inst %h", inst);

endmodule

// File: rv_ctrl_if.sv
`timescale 1ns/1ps

interface rv_ctrl_if import rv_pkg::*; ();

  logic      reg_write;
  logic      mem_write;
  logic      mem_read;
  mem_size_t mem_size;
  logic      mem_unsigned;
  alu_op_t   alu_op;
  logic      alu_b_imm;
  logic      branch_op;
  logic      jump_op;
  logic      pc_rel;
  logic      syscall_op;
  logic      break_op;
  logic      mret_op;
  logic      illegal;

  modport decoder (
    output reg_write, mem_write, mem_read, mem_size, mem_unsigned,
    output alu_op, alu_b_imm, branch_op, jump_op, pc_rel,
    output syscall_op, break_op, mret_op, illegal
  );

  modport issue (
    input reg_write, mem_write, mem_read, mem_size, mem_unsigned,
    input alu_op, alu_b_imm, branch_op, jump_op, pc_rel,
    input syscall_op, break_op, mret_op, illegal
  );

endinterface

// File: rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

  // Instruction, pc, immediate and target
  typedef logic [`xlen-1:0] word_t;

  // Register file index
  typedef logic [`reg_idx_w-1:0] reg_idx_t;

  // ALU operation code
  typedef logic [`alu_op_w-1:0] alu_op_t;

  // 0 byte, 1 halfword, 2 word
  typedef logic [`mem_size_w-1:0] mem_size_t;

  // Issue handshake FSM
  typedef enum logic [1:0] {
    IDLE,
    ACK,
    OFFER,
    RELEASE
  } issue_state_t;

endpackage

// File: rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath widths
`define xlen       32
`define reg_idx_w  5
`define alu_op_w   4
`define mem_size_w 2

// Major opcodes
`define op_lui    7'b0110111
`define op_auipc  7'b0010111
`define op_jal    7'b1101111
`define op_jalr   7'b1100111
`define op_branch 7'b1100011
`define op_load   7'b0000011
`define op_store  7'b0100011
`define op_imm    7'b0010011
`define op_reg    7'b0110011
`define op_system 7'b1110011

// funct3 codes
`define f3_jalr    3'b000
`define f3_beq     3'b000
`define f3_bne     3'b001
`define f3_blt     3'b100
`define f3_bge     3'b101
`define f3_bltu    3'b110
`define f3_bgeu    3'b111
`define f3_lb      3'b000
`define f3_lh      3'b001
`define f3_lw      3'b010
`define f3_lbu     3'b100
`define f3_lhu     3'b101
`define f3_sb      3'b000
`define f3_sh      3'b001
`define f3_sw      3'b010
`define f3_add_sub 3'b000
`define f3_sll     3'b001
`define f3_slt     3'b010
`define f3_sltu    3'b011
`define f3_xor     3'b100
`define f3_sr      3'b101
`define f3_or      3'b110
`define f3_and     3'b111

// funct7 codes
`define f7_base 7'b0000000
`define f7_alt  7'b0100000

// System encodings, compared against inst[31:7]
`define sys_ecall  25'h0000000
`define sys_ebreak 25'h0002000
`define sys_mret   25'h0604000

// ALU codes
`define alu_add  4'd0
`define alu_sub  4'd1
`define alu_and  4'd2
`define alu_or   4'd3
`define alu_xor  4'd4
`define alu_sll  4'd5
`define alu_sra  4'd6
`define alu_srl  4'd7
`define alu_slt  4'd8
`define alu_sltu 4'd9

`endif
